// File: mem_pkg.sv
package mem_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [3:0]  strb_t;

	// --------------------------------------------------------------------------
	// address map
	// --------------------------------------------------------------------------
	localparam addr_t SRAM_BASE  = 32'h8000_0000;
	localparam addr_t SRAM_MASK  = 32'hF000_0000;  // top nibble selects sram
	localparam addr_t CLINT_BASE = 32'h0200_0000;
	localparam addr_t CLINT_MASK = 32'hFFFF_0000;

	localparam addr_t CLINT_MTIME_LO_OFS = 32'h0000_0000;
	localparam addr_t CLINT_MTIME_HI_OFS = 32'h0000_0004;

	// icache geometry, one word per line
	localparam int ICACHE_INDEX_BITS = 4;
	localparam int ICACHE_TAG_BITS   = 26;
	localparam int ICACHE_LINES      = 1 << ICACHE_INDEX_BITS;

	// encoding follows funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} mem_size_e;

	typedef enum logic [1:0] {
		TGT_SRAM  = 2'd0,
		TGT_CLINT = 2'd1,
		TGT_FAULT = 2'd2
	} target_e;

	typedef enum logic [1:0] {
		ARB_IDLE  = 2'd0,
		ARB_FETCH = 2'd1,
		ARB_DATA  = 2'd2
	} arb_state_e;

	typedef enum logic [1:0] {
		IC_READY  = 2'd0,
		IC_REFILL = 2'd1,
		IC_FLUSH  = 2'd2
	} icache_state_e;

endpackage

// File: mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if;

	// request side, driven by the master
	logic           req;
	logic           we;
	mem_pkg::addr_t addr;
	mem_pkg::word_t wdata;
	mem_pkg::strb_t wstrb;

	// response side, driven by the arbiter
	logic           gnt;
	logic           rvalid;  // one pulse per accepted request
	mem_pkg::word_t rdata;
	logic           rerr;

	modport master (
		output req, we, addr, wdata, wstrb,
		input  gnt, rvalid, rdata, rerr
	);

	modport arbiter (
		input  req, we, addr, wdata, wstrb,
		output gnt, rvalid, rdata, rerr
	);

endinterface

// File: inst_cache.sv
`timescale 1ns/1ps

module inst_cache (
	input  logic             clock,
	input  logic             reset,
	input  logic             fetch_valid_i,
	input  mem_pkg::addr_t   fetch_addr_i,
	input  logic             fence_i_i,
	output logic             fetch_ready_o,
	output logic             inst_valid_o,
	output mem_pkg::word_t   inst_o,
	output logic             flush_done_o,
	mem_bus_if.master        bus_o
);

	mem_pkg::icache_state_e state_q;

	logic [mem_pkg::ICACHE_LINES-1:0]    valid_q;
	logic [mem_pkg::ICACHE_TAG_BITS-1:0] tag_mem  [mem_pkg::ICACHE_LINES];
	mem_pkg::word_t                      data_mem [mem_pkg::ICACHE_LINES];

	mem_pkg::addr_t miss_addr_q;
	mem_pkg::word_t inst_q;
	logic           req_q;
	logic           inst_valid_q;

	logic [mem_pkg::ICACHE_INDEX_BITS-1:0] fetch_idx, refill_idx;
	logic [mem_pkg::ICACHE_TAG_BITS-1:0]   fetch_tag, refill_tag;
	logic                                  hit;
	logic                                  accept;

	assign fetch_idx  = fetch_addr_i[2 +: mem_pkg::ICACHE_INDEX_BITS];
	assign fetch_tag  = fetch_addr_i[31 -: mem_pkg::ICACHE_TAG_BITS];
	assign refill_idx = miss_addr_q[2 +: mem_pkg::ICACHE_INDEX_BITS];
	assign refill_tag = miss_addr_q[31 -: mem_pkg::ICACHE_TAG_BITS];

	assign hit    = valid_q[fetch_idx] && (tag_mem[fetch_idx] == fetch_tag);
	assign accept = fetch_valid_i && fetch_ready_o;

	assign fetch_ready_o = (state_q == mem_pkg::IC_READY) && !fence_i_i;  // fence wins
	assign inst_valid_o  = inst_valid_q;
	assign inst_o        = inst_q;
	assign flush_done_o  = (state_q == mem_pkg::IC_FLUSH);

	// read-only master
	assign bus_o.req   = req_q;
	assign bus_o.we    = 1'b0;
	assign bus_o.addr  = miss_addr_q;
	assign bus_o.wdata = '0;
	assign bus_o.wstrb = '0;

	// --------------------------------------------------------------------------
	// control FSM
	// --------------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state_q      <= mem_pkg::IC_READY;
			valid_q      <= '0;
			req_q        <= 1'b0;
			inst_valid_q <= 1'b0;
		end else begin
			inst_valid_q <= 1'b0;
			case (state_q)
				mem_pkg::IC_READY: begin
					if (fence_i_i) begin
						state_q <= mem_pkg::IC_FLUSH;
					end else if (accept) begin
						if (hit) begin
							inst_valid_q <= 1'b1;
						end else begin
							state_q <= mem_pkg::IC_REFILL;
							req_q   <= 1'b1;
						end
					end
				end
				mem_pkg::IC_REFILL: begin
					if (req_q && bus_o.gnt)
						req_q <= 1'b0;
					if (bus_o.rvalid) begin
						valid_q[refill_idx] <= !bus_o.rerr;  // faulted line stays invalid
						inst_valid_q        <= 1'b1;
						state_q             <= mem_pkg::IC_READY;
					end
				end
				mem_pkg::IC_FLUSH: begin
					valid_q <= '0;
					state_q <= mem_pkg::IC_READY;
				end
				default: state_q <= mem_pkg::IC_READY;
			endcase
		end
	end

	// line storage and returned word
	always_ff @(posedge clock) begin
		if (accept) begin
			miss_addr_q <= {fetch_addr_i[31:2], 2'b00};
			inst_q      <= data_mem[fetch_idx];
		end
		if ((state_q == mem_pkg::IC_REFILL) && bus_o.rvalid) begin
			inst_q <= bus_o.rerr ? '0 : bus_o.rdata;
			if (!bus_o.rerr) begin
				tag_mem[refill_idx]  <= refill_tag;
				data_mem[refill_idx] <= bus_o.rdata;
			end
		end
	end

endmodule

// File: load_store_port.sv
`timescale 1ns/1ps

module load_store_port (
	input  logic               clock,
	input  logic               reset,
	input  logic               lsu_valid_i,
	input  logic               lsu_write_i,
	input  mem_pkg::mem_size_e lsu_size_i,
	input  logic               lsu_unsigned_i,
	input  mem_pkg::addr_t     lsu_addr_i,
	input  mem_pkg::word_t     lsu_wdata_i,
	output logic               lsu_ready_o,
	output logic               lsu_rvalid_o,
	output mem_pkg::word_t     lsu_rdata_o,
	output logic               lsu_fault_o,
	mem_bus_if.master          bus_o
);

	logic busy_q;
	logic req_q;

	// request fields, held until the grant
	logic           we_q;
	mem_pkg::addr_t addr_q;
	mem_pkg::word_t wdata_q;
	mem_pkg::strb_t wstrb_q;

	// kept until the response for load extraction
	mem_pkg::mem_size_e size_q;
	logic               unsigned_q;
	logic [1:0]         suffix_q;

	mem_pkg::word_t lane_data;
	mem_pkg::strb_t lane_strb;
	mem_pkg::word_t shifted;

	assign lsu_ready_o = !busy_q;

	// --------------------------------------------------------------------------
	// store lane placement
	// --------------------------------------------------------------------------
	always_comb begin
		case (lsu_size_i)
			mem_pkg::SIZE_BYTE: begin
				lane_data = {4{lsu_wdata_i[7:0]}};
				lane_strb = 4'b0001 << lsu_addr_i[1:0];
			end
			mem_pkg::SIZE_HALF: begin
				lane_data = {2{lsu_wdata_i[15:0]}};
				lane_strb = 4'b0011 << {lsu_addr_i[1], 1'b0};
			end
			default: begin
				lane_data = lsu_wdata_i;
				lane_strb = 4'b1111;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy_q <= 1'b0;
			req_q  <= 1'b0;
		end else begin
			if (lsu_valid_i && lsu_ready_o) begin
				busy_q <= 1'b1;
				req_q  <= 1'b1;
			end
			if (req_q && bus_o.gnt)
				req_q <= 1'b0;
			if (bus_o.rvalid)
				busy_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (lsu_valid_i && lsu_ready_o) begin
			we_q       <= lsu_write_i;
			addr_q     <= {lsu_addr_i[31:2], 2'b00};  // word aligned on the bus
			wdata_q    <= lane_data;
			wstrb_q    <= lsu_write_i ? lane_strb : 4'b0000;
			size_q     <= lsu_size_i;
			unsigned_q <= lsu_unsigned_i;
			suffix_q   <= lsu_addr_i[1:0];
		end
	end

	assign bus_o.req   = req_q;
	assign bus_o.we    = we_q;
	assign bus_o.addr  = addr_q;
	assign bus_o.wdata = wdata_q;
	assign bus_o.wstrb = wstrb_q;

	// load extraction and extension
	assign shifted = bus_o.rdata >> {suffix_q, 3'b000};

	always_comb begin
		case (size_q)
			mem_pkg::SIZE_BYTE:
				lsu_rdata_o = {{24{shifted[7] & !unsigned_q}}, shifted[7:0]};
			mem_pkg::SIZE_HALF:
				lsu_rdata_o = {{16{shifted[15] & !unsigned_q}}, shifted[15:0]};
			default:
				lsu_rdata_o = bus_o.rdata;
		endcase
	end

	assign lsu_rvalid_o = bus_o.rvalid;
	assign lsu_fault_o  = bus_o.rvalid && bus_o.rerr;

endmodule

// File: bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
	input  logic           clock,
	input  logic           reset,
	mem_bus_if.arbiter     fetch_bus_i,
	mem_bus_if.arbiter     data_bus_i,
	output logic           sram_req_o,
	output logic           sram_we_o,
	output mem_pkg::addr_t sram_addr_o,
	output mem_pkg::word_t sram_wdata_o,
	output mem_pkg::strb_t sram_wstrb_o,
	input  logic           sram_ready_i,
	input  logic           sram_rvalid_i,
	input  mem_pkg::word_t sram_rdata_i,
	output mem_pkg::addr_t timer_addr_o,
	input  mem_pkg::word_t timer_rdata_i
);

	mem_pkg::arb_state_e state_q;
	mem_pkg::target_e    tgt;

	logic           fetch_gnt, data_gnt, grant;
	mem_pkg::addr_t sel_addr;
	logic           sel_we;
	mem_pkg::word_t sel_wdata;
	mem_pkg::strb_t sel_wstrb;

	logic           sram_req_q, sram_we_q;
	mem_pkg::addr_t sram_addr_q;
	mem_pkg::word_t sram_wdata_q;
	mem_pkg::strb_t sram_wstrb_q;

	logic           rvalid_q, rerr_q;
	mem_pkg::word_t rdata_q;

	function automatic mem_pkg::target_e decode(input mem_pkg::addr_t addr, input logic we);
		if ((addr & mem_pkg::SRAM_MASK) == mem_pkg::SRAM_BASE)
			return mem_pkg::TGT_SRAM;
		else if ((addr & mem_pkg::CLINT_MASK) == mem_pkg::CLINT_BASE)
			return we ? mem_pkg::TGT_FAULT : mem_pkg::TGT_CLINT;  // timer is read only
		else
			return mem_pkg::TGT_FAULT;
	endfunction

	// --------------------------------------------------------------------------
	// grant, data side wins ties
	// --------------------------------------------------------------------------
	assign data_gnt  = (state_q == mem_pkg::ARB_IDLE) && data_bus_i.req;
	assign fetch_gnt = (state_q == mem_pkg::ARB_IDLE) && fetch_bus_i.req && !data_bus_i.req;
	assign grant     = data_gnt || fetch_gnt;

	assign sel_addr  = data_bus_i.req ? data_bus_i.addr  : fetch_bus_i.addr;
	assign sel_we    = data_bus_i.req ? data_bus_i.we    : fetch_bus_i.we;
	assign sel_wdata = data_bus_i.req ? data_bus_i.wdata : fetch_bus_i.wdata;
	assign sel_wstrb = data_bus_i.req ? data_bus_i.wstrb : fetch_bus_i.wstrb;
	assign tgt       = decode(sel_addr, sel_we);

	assign timer_addr_o = sel_addr;  // clint read is sampled in the grant cycle

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q    <= mem_pkg::ARB_IDLE;
			sram_req_q <= 1'b0;
			rvalid_q   <= 1'b0;
		end else begin
			rvalid_q <= 1'b0;
			case (state_q)
				mem_pkg::ARB_IDLE: begin
					if (grant) begin
						state_q <= data_gnt ? mem_pkg::ARB_DATA : mem_pkg::ARB_FETCH;
						if (tgt == mem_pkg::TGT_SRAM)
							sram_req_q <= 1'b1;
						else
							rvalid_q <= 1'b1;  // clint and faults answer next cycle
					end
				end
				default: begin
					if (sram_req_q && sram_ready_i)
						sram_req_q <= 1'b0;
					if (rvalid_q)
						state_q <= mem_pkg::ARB_IDLE;
					else if (sram_rvalid_i)
						rvalid_q <= 1'b1;
				end
			endcase
		end
	end

	// forwarded request and response payload
	always_ff @(posedge clock) begin
		if (grant) begin
			sram_we_q    <= sel_we;
			sram_addr_q  <= sel_addr;
			sram_wdata_q <= sel_wdata;
			sram_wstrb_q <= sel_wstrb;
			rerr_q       <= (tgt == mem_pkg::TGT_FAULT);
			rdata_q      <= (tgt == mem_pkg::TGT_CLINT) ? timer_rdata_i : '0;
		end else if ((state_q != mem_pkg::ARB_IDLE) && sram_rvalid_i) begin
			rerr_q  <= 1'b0;
			rdata_q <= sram_rdata_i;
		end
	end

	assign sram_req_o   = sram_req_q;
	assign sram_we_o    = sram_we_q;
	assign sram_addr_o  = sram_addr_q;
	assign sram_wdata_o = sram_wdata_q;
	assign sram_wstrb_o = sram_wstrb_q;

	assign fetch_bus_i.gnt    = fetch_gnt;
	assign fetch_bus_i.rvalid = rvalid_q && (state_q == mem_pkg::ARB_FETCH);
	assign fetch_bus_i.rdata  = rdata_q;
	assign fetch_bus_i.rerr   = rerr_q;

	assign data_bus_i.gnt    = data_gnt;
	assign data_bus_i.rvalid = rvalid_q && (state_q == mem_pkg::ARB_DATA);
	assign data_bus_i.rdata  = rdata_q;
	assign data_bus_i.rerr   = rerr_q;

endmodule

// File: clint_timer.sv
`timescale 1ns/1ps

module clint_timer (
	input  logic           clock,
	input  logic           reset,
	input  mem_pkg::addr_t timer_addr_i,
	output mem_pkg::word_t timer_rdata_o
);

	logic [63:0]    mtime_q;
	mem_pkg::addr_t offset;

	// free running, zero right after reset
	always_ff @(posedge clock) begin
		if (reset)
			mtime_q <= '0;
		else
			mtime_q <= mtime_q + 64'd1;
	end

	assign offset = timer_addr_i & ~mem_pkg::CLINT_MASK;

	always_comb begin
		case (offset)
			mem_pkg::CLINT_MTIME_LO_OFS: timer_rdata_o = mtime_q[31:0];
			mem_pkg::CLINT_MTIME_HI_OFS: timer_rdata_o = mtime_q[63:32];
			default:                     timer_rdata_o = '0;  // unmapped offsets read zero
		endcase
	end

endmodule

// File: mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top (
	input  logic               clock,
	input  logic               reset,

	// fetch side
	input  logic               fetch_valid_i,
	input  mem_pkg::addr_t     fetch_addr_i,
	output logic               fetch_ready_o,
	output logic               inst_valid_o,
	output mem_pkg::word_t     inst_o,
	input  logic               fence_i_i,
	output logic               flush_done_o,

	// data side
	input  logic               lsu_valid_i,
	input  logic               lsu_write_i,
	input  mem_pkg::mem_size_e lsu_size_i,
	input  logic               lsu_unsigned_i,
	input  mem_pkg::addr_t     lsu_addr_i,
	input  mem_pkg::word_t     lsu_wdata_i,
	output logic               lsu_ready_o,
	output logic               lsu_rvalid_o,
	output mem_pkg::word_t     lsu_rdata_o,
	output logic               lsu_fault_o,

	// external sram
	output logic               sram_req_o,
	output logic               sram_we_o,
	output mem_pkg::addr_t     sram_addr_o,
	output mem_pkg::word_t     sram_wdata_o,
	output mem_pkg::strb_t     sram_wstrb_o,
	input  logic               sram_ready_i,
	input  logic               sram_rvalid_i,
	input  mem_pkg::word_t     sram_rdata_i
);

	mem_bus_if fetch_bus ();
	mem_bus_if data_bus ();

	mem_pkg::addr_t timer_addr;
	mem_pkg::word_t timer_rdata;

	inst_cache u_icache (
		.clock         (clock),
		.reset         (reset),
		.fetch_valid_i (fetch_valid_i),
		.fetch_addr_i  (fetch_addr_i),
		.fence_i_i     (fence_i_i),
		.fetch_ready_o (fetch_ready_o),
		.inst_valid_o  (inst_valid_o),
		.inst_o        (inst_o),
		.flush_done_o  (flush_done_o),
		.bus_o         (fetch_bus)
	);

	load_store_port u_lsu (
		.clock          (clock),
		.reset          (reset),
		.lsu_valid_i    (lsu_valid_i),
		.lsu_write_i    (lsu_write_i),
		.lsu_size_i     (lsu_size_i),
		.lsu_unsigned_i (lsu_unsigned_i),
		.lsu_addr_i     (lsu_addr_i),
		.lsu_wdata_i    (lsu_wdata_i),
		.lsu_ready_o    (lsu_ready_o),
		.lsu_rvalid_o   (lsu_rvalid_o),
		.lsu_rdata_o    (lsu_rdata_o),
		.lsu_fault_o    (lsu_fault_o),
		.bus_o          (data_bus)
	);

	bus_arbiter u_arbiter (
		.clock         (clock),
		.reset         (reset),
		.fetch_bus_i   (fetch_bus),
		.data_bus_i    (data_bus),
		.sram_req_o    (sram_req_o),
		.sram_we_o     (sram_we_o),
		.sram_addr_o   (sram_addr_o),
		.sram_wdata_o  (sram_wdata_o),
		.sram_wstrb_o  (sram_wstrb_o),
		.sram_ready_i  (sram_ready_i),
		.sram_rvalid_i (sram_rvalid_i),
		.sram_rdata_i  (sram_rdata_i),
		.timer_addr_o  (timer_addr),
		.timer_rdata_i (timer_rdata)
	);

	clint_timer u_clint (
		.clock         (clock),
		.reset         (reset),
		.timer_addr_i  (timer_addr),
		.timer_rdata_o (timer_rdata)
	);

endmodule

// File: mem_subsystem_assertions.sv
`timescale 1ns/1ps

module mem_subsystem_assertions (
	input logic           clock,
	input logic           reset,
	input logic           sram_req_i,
	input logic           sram_we_i,
	input mem_pkg::addr_t sram_addr_i,
	input mem_pkg::word_t sram_wdata_i,
	input mem_pkg::strb_t sram_wstrb_i,
	input logic           sram_ready_i,
	input logic           inst_valid_i,
	input logic           flush_done_i
);

	int fail_count = 0;  // read by the testbench at the end

	// request frozen while the sram stalls
	sram_hold: assert property (@(posedge clock) disable iff (reset)
		(sram_req_i && !sram_ready_i) |=> (sram_req_i && $stable(sram_we_i)
			&& $stable(sram_addr_i) && $stable(sram_wdata_i) && $stable(sram_wstrb_i)))
		else begin
			fail_count++;
			$error("sram request changed while sram_ready_i was low");
		end

	inst_pulse: assert property (@(posedge clock) disable iff (reset)
		inst_valid_i |=> !inst_valid_i)
		else begin
			fail_count++;
			$error("inst_valid_o held high for more than one cycle");
		end

	flush_pulse: assert property (@(posedge clock) disable iff (reset)
		flush_done_i |=> !flush_done_i)
		else begin
			fail_count++;
			$error("flush_done_o held high for more than one cycle");
		end

	reset_idle: assert property (@(posedge clock) reset |=> !sram_req_i)
		else begin
			fail_count++;
			$error("sram_req_o high right after a reset cycle");
		end

endmodule

bind mem_subsystem_top mem_subsystem_assertions u_assertions (
	.clock        (clock),
	.reset        (reset),
	.sram_req_i   (sram_req_o),
	.sram_we_i    (sram_we_o),
	.sram_addr_i  (sram_addr_o),
	.sram_wdata_i (sram_wdata_o),
	.sram_wstrb_i (sram_wstrb_o),
	.sram_ready_i (sram_ready_i),
	.inst_valid_i (inst_valid_o),
	.flush_done_i (flush_done_o)
);

// File: tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;

	localparam int             TIMEOUT    = 200;
	localparam mem_pkg::addr_t FETCH_BASE = 32'h8000_0000;
	localparam mem_pkg::addr_t DATA_BASE  = 32'h8000_1000;
	localparam mem_pkg::addr_t SMC_ADDR   = 32'h8000_2040;  // word rewritten under the cache

	logic               clock;
	logic               reset;
	logic               fetch_valid_i;
	mem_pkg::addr_t     fetch_addr_i;
	logic               fetch_ready_o;
	logic               inst_valid_o;
	mem_pkg::word_t     inst_o;
	logic               fence_i_i;
	logic               flush_done_o;
	logic               lsu_valid_i;
	logic               lsu_write_i;
	mem_pkg::mem_size_e lsu_size_i;
	logic               lsu_unsigned_i;
	mem_pkg::addr_t     lsu_addr_i;
	mem_pkg::word_t     lsu_wdata_i;
	logic               lsu_ready_o;
	logic               lsu_rvalid_o;
	mem_pkg::word_t     lsu_rdata_o;
	logic               lsu_fault_o;
	logic               sram_req_o;
	logic               sram_we_o;
	mem_pkg::addr_t     sram_addr_o;
	mem_pkg::word_t     sram_wdata_o;
	mem_pkg::strb_t     sram_wstrb_o;
	logic               sram_ready_i;
	logic               sram_rvalid_i;
	mem_pkg::word_t     sram_rdata_i;

	logic [31:0] stim_rng;
	logic [31:0] fetch_rng;
	logic [31:0] sram_rng;

	mem_pkg::word_t sram_mem [mem_pkg::addr_t];  // what the DUT actually wrote
	mem_pkg::word_t ref_mem  [mem_pkg::addr_t];  // what it should have written

	mem_pkg::word_t inst_exp_q  [$];
	mem_pkg::word_t lsu_data_q  [$];
	logic           lsu_check_q [$];
	logic           lsu_fault_q [$];

	int mismatch_count = 0;
	int failure_count  = 0;
	int sram_req_cycles;

	mem_subsystem_top UUT (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic mem_pkg::word_t fill_word(input mem_pkg::addr_t a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
	endfunction

	function automatic mem_pkg::word_t ref_read(input mem_pkg::addr_t a);
		mem_pkg::addr_t k;
		k = {a[31:2], 2'b00};
		return ref_mem.exists(k) ? ref_mem[k] : fill_word(k);
	endfunction

	function automatic mem_pkg::word_t sram_read(input mem_pkg::addr_t a);
		return sram_mem.exists(a) ? sram_mem[a] : fill_word(a);
	endfunction

	function automatic void sram_write(input mem_pkg::addr_t a, input mem_pkg::word_t d,
			input mem_pkg::strb_t strb);
		mem_pkg::word_t w;
		w = sram_read(a);
		for (int i = 0; i < 4; i++)
			if (strb[i])
				w[8*i +: 8] = d[8*i +: 8];
		sram_mem[a] = w;
	endfunction

	// bytes land at the addressed offset with the lowest data byte first
	function automatic void ref_store(input mem_pkg::addr_t a, input mem_pkg::mem_size_e size,
			input mem_pkg::word_t d);
		mem_pkg::word_t w;
		int             n;
		w = ref_read(a);
		n = (size == mem_pkg::SIZE_BYTE) ? 1 : (size == mem_pkg::SIZE_HALF) ? 2 : 4;
		for (int i = 0; i < n; i++)
			w[8*(int'(a[1:0]) + i) +: 8] = d[8*i +: 8];
		ref_mem[{a[31:2], 2'b00}] = w;
	endfunction

	// expected load result
	function automatic mem_pkg::word_t expected_load(input mem_pkg::word_t w,
			input mem_pkg::mem_size_e size, input logic uns, input logic [1:0] ofs);
		logic [7:0]  b;
		logic [15:0] h;
		b = w[{ofs, 3'b000} +: 8];
		h = w[{ofs[1], 4'b0000} +: 16];
		case (size)
			mem_pkg::SIZE_BYTE: return uns ? {24'h0, b} : {{24{b[7]}}, b};
			mem_pkg::SIZE_HALF: return uns ? {16'h0, h} : {{16{h[15]}}, h};
			default:            return w;
		endcase
	endfunction

	function automatic mem_pkg::mem_size_e size_from(input logic [1:0] r);
		case (r)
			2'd0:    return mem_pkg::SIZE_BYTE;
			2'd1:    return mem_pkg::SIZE_HALF;
			default: return mem_pkg::SIZE_WORD;
		endcase
	endfunction

	function automatic mem_pkg::addr_t aligned(input mem_pkg::addr_t a,
			input mem_pkg::mem_size_e size);
		case (size)
			mem_pkg::SIZE_BYTE: return a;
			mem_pkg::SIZE_HALF: return {a[31:1], 1'b0};
			default:            return {a[31:2], 2'b00};
		endcase
	endfunction

	task automatic check_word(input string name, input mem_pkg::word_t got,
			input mem_pkg::word_t exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("MISMATCH %0t %s got %08h expected %08h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("MISMATCH %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(input string msg);
		failure_count++;
		$display("ERROR %0t %s", $time, msg);
	endtask

	task automatic print_counts;
		$display("checks done: %0d mismatches, %0d other errors, %0d assertion failures",
			mismatch_count, failure_count, UUT.u_assertions.fail_count);
	endtask

	task automatic give_up(input string what);
		$display("ERROR %0t timed out waiting for %s", $time, what);
		print_counts();
		$display("Simulation failed");
		$finish;
	endtask

	// ------------------------------------------------------------------------
	// sram model with random accept stalls and response delay
	// ------------------------------------------------------------------------
	initial begin : sram_model
		logic           pending;
		logic [1:0]     delay;
		mem_pkg::word_t rsp;
		pending         = 1'b0;
		delay           = 2'd0;
		rsp             = '0;
		sram_req_cycles = 0;
		sram_rng        = xorshift(32'h74b5 ^ 32'h0000_ffff);
		sram_ready_i    = 1'b1;
		sram_rvalid_i   = 1'b0;
		sram_rdata_i    = '0;
		forever begin
			@(posedge clock);
			if (!reset && sram_req_o) begin
				sram_req_cycles++;
				if (sram_ready_i) begin
					rsp = sram_we_o ? '0 : sram_read(sram_addr_o);
					if (sram_we_o)
						sram_write(sram_addr_o, sram_wdata_o, sram_wstrb_o);
					pending  = 1'b1;
					sram_rng = xorshift(sram_rng);
					delay    = sram_rng[1:0];
				end
			end
			@(negedge clock);
			sram_rvalid_i = 1'b0;
			if (pending) begin
				if (delay == 2'd0) begin
					sram_rvalid_i = 1'b1;
					sram_rdata_i  = rsp;
					pending       = 1'b0;
				end else
					delay--;
			end
			sram_rng     = xorshift(sram_rng);
			sram_ready_i = (sram_rng[1:0] != 2'b00);  // stall about one cycle in four
		end
	end

	// compare process
	always @(posedge clock) begin
		mem_pkg::word_t exp_d;
		logic           chk;
		logic           flt;
		if (!reset && inst_valid_o) begin
			if (inst_exp_q.size() == 0)
				report_failure("inst_valid_o pulsed with no fetch outstanding");
			else
				check_word("inst_o", inst_o, inst_exp_q.pop_front());
		end
		if (!reset && lsu_rvalid_o) begin
			if (lsu_data_q.size() == 0)
				report_failure("lsu_rvalid_o pulsed with no access outstanding");
			else begin
				exp_d = lsu_data_q.pop_front();
				chk   = lsu_check_q.pop_front();
				flt   = lsu_fault_q.pop_front();
				check_bit("lsu_fault_o", lsu_fault_o, flt);
				if (chk)
					check_word("lsu_rdata_o", lsu_rdata_o, exp_d);
			end
		end
	end

	// ------------------------------------------------------------------------
	// stimulus tasks
	// ------------------------------------------------------------------------
	task automatic fetch(input mem_pkg::addr_t a, input mem_pkg::word_t exp, output int lat);
		int   n;
		logic accepted;
		logic done;
		inst_exp_q.push_back(exp);
		@(negedge clock);
		fetch_valid_i = 1'b1;
		fetch_addr_i  = a;
		accepted      = 1'b0;
		n             = 0;
		while (!accepted && n < TIMEOUT) begin
			@(posedge clock);
			accepted = fetch_ready_o;
			n++;
		end
		if (!accepted)
			give_up("fetch_ready_o");
		@(negedge clock);
		fetch_valid_i = 1'b0;
		done          = 1'b0;
		lat           = 0;  // counted from the accepting edge
		while (!done && lat < TIMEOUT) begin
			@(posedge clock);
			done = inst_valid_o;
			lat++;
		end
		if (!done)
			give_up("inst_valid_o");
	endtask

	task automatic lsu_access(input logic wr, input mem_pkg::mem_size_e size, input logic uns,
			input mem_pkg::addr_t a, input mem_pkg::word_t d, output mem_pkg::word_t rd);
		int   n;
		logic accepted;
		logic done;
		@(negedge clock);
		lsu_valid_i    = 1'b1;
		lsu_write_i    = wr;
		lsu_size_i     = size;
		lsu_unsigned_i = uns;
		lsu_addr_i     = a;
		lsu_wdata_i    = d;
		accepted       = 1'b0;
		n              = 0;
		while (!accepted && n < TIMEOUT) begin
			@(posedge clock);
			accepted = lsu_ready_o;
			n++;
		end
		if (!accepted)
			give_up("lsu_ready_o");
		@(negedge clock);
		lsu_valid_i = 1'b0;
		done        = 1'b0;
		n           = 0;
		while (!done && n < TIMEOUT) begin
			@(posedge clock);
			done = lsu_rvalid_o;
			rd   = lsu_rdata_o;
			n++;
		end
		if (!done)
			give_up("lsu_rvalid_o");
	endtask

	task automatic expect_lsu(input mem_pkg::word_t d, input logic chk, input logic flt);
		lsu_data_q.push_back(d);
		lsu_check_q.push_back(chk);
		lsu_fault_q.push_back(flt);
	endtask

	task automatic store(input mem_pkg::mem_size_e size, input mem_pkg::addr_t a,
			input mem_pkg::word_t d);
		mem_pkg::word_t rd;
		ref_store(a, size, d);
		expect_lsu('0, 1'b0, 1'b0);
		lsu_access(1'b1, size, 1'b0, a, d, rd);
	endtask

	task automatic load(input mem_pkg::mem_size_e size, input logic uns, input mem_pkg::addr_t a);
		mem_pkg::word_t rd;
		expect_lsu(expected_load(ref_read(a), size, uns, a[1:0]), 1'b1, 1'b0);
		lsu_access(1'b0, size, uns, a, '0, rd);
	endtask

	task automatic flush_icache;
		int   lat;
		logic done;
		@(negedge clock);
		fence_i_i = 1'b1;
		@(negedge clock);
		fence_i_i = 1'b0;
		done      = 1'b0;
		lat       = 0;
		while (!done && lat < TIMEOUT) begin
			@(posedge clock);
			done = flush_done_o;
			lat++;
		end
		if (!done)
			give_up("flush_done_o");
		if (lat != 1)
			report_failure($sformatf("flush_done_o came %0d cycles after fence.i", lat));
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		mem_pkg::addr_t     addr;
		mem_pkg::mem_size_e size;
		mem_pkg::word_t     old_w;
		mem_pkg::word_t     rd;
		mem_pkg::word_t     t0;
		mem_pkg::word_t     t1;
		int                 lat;
		int                 req_before;
		stim_rng       = 32'h74b5;
		fetch_rng      = xorshift(32'h74b5);
		reset          = 1'b1;
		fetch_valid_i  = 1'b0;
		fetch_addr_i   = '0;
		fence_i_i      = 1'b0;
		lsu_valid_i    = 1'b0;
		lsu_write_i    = 1'b0;
		lsu_size_i     = mem_pkg::SIZE_WORD;
		lsu_unsigned_i = 1'b0;
		lsu_addr_i     = '0;
		lsu_wdata_i    = '0;
		repeat (8) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		check_bit("sram_req_o", sram_req_o, 1'b0);
		check_bit("inst_valid_o", inst_valid_o, 1'b0);
		check_bit("flush_done_o", flush_done_o, 1'b0);
		check_bit("lsu_rvalid_o", lsu_rvalid_o, 1'b0);
		check_bit("fetch_ready_o", fetch_ready_o, 1'b1);
		check_bit("lsu_ready_o", lsu_ready_o, 1'b1);

		// random stores followed by loads of every size in both sign modes
		for (int i = 0; i < 24; i++) begin
			stim_rng = xorshift(stim_rng);
			size     = size_from(stim_rng[1:0]);
			addr     = aligned(DATA_BASE + {26'd0, stim_rng[9:4]}, size);
			stim_rng = xorshift(stim_rng);
			store(size, addr, stim_rng);
		end
		for (int s = 0; s < 3; s++)
			for (int u = 0; u < 2; u++)
				for (int i = 0; i < 6; i++) begin
					stim_rng = xorshift(stim_rng);
					size     = size_from(s[1:0]);
					addr     = aligned(DATA_BASE + {26'd0, stim_rng[9:4]}, size);
					load(size, u[0], addr);
				end

		// miss then hit
		addr = FETCH_BASE + 32'h18;
		fetch(addr, ref_read(addr), lat);
		fetch(addr, ref_read(addr), lat);
		if (lat != 1)
			report_failure($sformatf("cache hit answered after %0d cycles", lat));

		// no snooping until fence.i
		old_w = ref_read(SMC_ADDR);
		fetch(SMC_ADDR, old_w, lat);
		store(mem_pkg::SIZE_WORD, SMC_ADDR, ~old_w);
		fetch(SMC_ADDR, old_w, lat);
		flush_icache();
		fetch(SMC_ADDR, ref_read(SMC_ADDR), lat);

		// both masters at once
		fork
			begin
				mem_pkg::addr_t fa;
				int             flat;
				for (int i = 0; i < 16; i++) begin
					fetch_rng = xorshift(fetch_rng);
					fa        = FETCH_BASE + {25'd0, fetch_rng[6:2], 2'b00};
					fetch(fa, ref_read(fa), flat);
				end
			end
			begin
				mem_pkg::addr_t     da;
				mem_pkg::mem_size_e ds;
				for (int i = 0; i < 16; i++) begin
					stim_rng = xorshift(stim_rng);
					ds       = size_from(stim_rng[1:0]);
					da       = aligned(DATA_BASE + {26'd0, stim_rng[9:4]}, ds);
					if (stim_rng[12])
						store(ds, da, xorshift(stim_rng));
					else
						load(ds, stim_rng[13], da);
				end
			end
		join

		// clint timer
		expect_lsu('0, 1'b1, 1'b0);
		lsu_access(1'b0, mem_pkg::SIZE_WORD, 1'b0,
			mem_pkg::CLINT_BASE + mem_pkg::CLINT_MTIME_HI_OFS, '0, rd);
		expect_lsu('0, 1'b0, 1'b0);
		lsu_access(1'b0, mem_pkg::SIZE_WORD, 1'b0,
			mem_pkg::CLINT_BASE + mem_pkg::CLINT_MTIME_LO_OFS, '0, t0);
		expect_lsu('0, 1'b0, 1'b0);
		lsu_access(1'b0, mem_pkg::SIZE_WORD, 1'b0,
			mem_pkg::CLINT_BASE + mem_pkg::CLINT_MTIME_LO_OFS, '0, t1);
		if (!(t1 > t0))
			report_failure($sformatf("mtime low word did not increase, %08h then %08h", t0, t1));

		// unmapped load and clint store both fault
		req_before = sram_req_cycles;
		expect_lsu('0, 1'b1, 1'b1);
		lsu_access(1'b0, mem_pkg::SIZE_WORD, 1'b0, 32'h4000_0010, '0, rd);
		expect_lsu('0, 1'b0, 1'b1);
		lsu_access(1'b1, mem_pkg::SIZE_WORD, 1'b0, mem_pkg::CLINT_BASE, 32'h1234_5678, rd);
		if (sram_req_cycles != req_before)
			report_failure("a faulting access raised sram_req_o");

		print_counts();
		if (mismatch_count == 0 && failure_count == 0 && UUT.u_assertions.fail_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: list.f
mem_pkg.sv
mem_bus_if.sv
inst_cache.sv
load_store_port.sv
bus_arbiter.sv
clint_timer.sv
mem_subsystem_top.sv
mem_subsystem_assertions.sv
tb_mem_subsystem.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -f list.f --top-module tb_mem_subsystem \
	&& ./obj_dir/Vtb_mem_subsystem | tee /dev/stderr | grep "^Simulation passed$" > /dev/null \
	&& echo "run.sh: PASS" \
	|| { echo "run.sh: FAIL"; exit 1; }
